/* logic/isa_pkg.sv */
// ==================================================
// Instruction-set definitions
// Opcode encodings, the 48-bit base instruction
// layout and architectural register numbering
// ==================================================
`default_nettype none

package isa_pkg;

	// ================================================
	// Architectural registers
	// ================================================

	// Seven bits reach the full register file, which only a postfix can address
	typedef logic [6:0] aregno_t;

	// The base instruction fields are one bit narrower and cover registers 0 to 63
	typedef logic [5:0] base_regno_t;

	// Hardwired register that always reads as zero
	localparam aregno_t AREG_ZERO = 7'd127;

	// Register number that aliases the instruction pointer
	localparam aregno_t AREG_IP = 7'd62;

	// ================================================
	// Opcodes
	// ================================================

	// Codes not listed here are illegal in the base parcel
	// REXT and IMMA are postfix opcodes and are only valid in the second parcel
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADDI  = 7'd4,
		OP_CSR   = 7'd7,
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_XORI  = 7'd10,
		OP_CMPI  = 7'd11,
		OP_SHIFT = 7'd12,
		OP_ADD   = 7'd16,
		OP_LOAD  = 7'd32,
		OP_STORE = 7'd40,
		OP_BCC   = 7'd48,
		OP_PUSH  = 7'd56,
		OP_POP   = 7'd57,
		OP_REXT  = 7'd122,
		OP_IMMA  = 7'd123
	} opcode_t;

	// ================================================
	// Instruction layout
	// ================================================

	// One 48-bit parcel of the instruction stream
	typedef logic [47:0] parcel_t;

	// Base instruction, opcode in the low bits
	// The upper bits hold immediates and are not decoded in this stage
	typedef struct packed {
		logic [22:0] upper;
		base_regno_t rs2;
		base_regno_t rs1;
		base_regno_t rd;
		opcode_t     opcode;
	} base_instr_t;

	// A fetch bundle is the base instruction with the following parcel above it
	typedef struct packed {
		parcel_t     parcel;
		base_instr_t base;
	} bundle_t;

endpackage

`default_nettype wire

/* logic/decode_pkg.sv */
// ==================================================
// Decode-stage record types
// Register flags, postfix summary and the decoded
// record handed on toward rename
// ==================================================
`default_nettype none

package decode_pkg;

	// Zero and instruction-pointer flags for one register number
	typedef struct packed {
		logic zero;
		logic ip;
	} areg_flags_t;

	// Flags for all three register fields, rs1 in the top bits
	typedef struct packed {
		areg_flags_t rs1;
		areg_flags_t rs2;
		areg_flags_t rd;
	} reg_flags_t;

	// What the second parcel contributes
	// The extended numbers are only meaningful when has_rext is set
	typedef struct packed {
		logic             has_rext;
		logic             has_imma;
		isa_pkg::aregno_t rs1;
		isa_pkg::aregno_t rs2;
		isa_pkg::aregno_t rd;
	} postfix_t;

	// One decoded record per bundle
	typedef struct packed {
		isa_pkg::base_instr_t instr;
		isa_pkg::aregno_t     rs1;
		isa_pkg::aregno_t     rs2;
		isa_pkg::aregno_t     rd;
		reg_flags_t           flags;
		logic                 illegal;
		logic                 has_rext;
		logic                 has_imma;
	} decoded_t;

endpackage

`default_nettype wire

/* logic/fetch_queue.sv */
// ==================================================
// Fetch queue
// Circular buffer of instruction bundles between
// the fetch stream and the decode logic
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module fetch_queue #(
	parameter int DEPTH = 4
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              in_valid,
	output logic             in_ready,
	input  wire isa_pkg::bundle_t in_bundle,
	output logic             head_valid,
	input  wire              head_ready,
	output isa_pkg::bundle_t head_bundle
);
	import isa_pkg::*;

	// A single-entry queue still needs one pointer bit
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	// The count has to reach DEPTH itself, so it gets one extra state
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] count_t;

	bundle_t entries [DEPTH];
	ptr_t    wr_ptr;
	ptr_t    rd_ptr;
	count_t  count;
	logic    full;
	logic    push;
	logic    pop;

	// Pointers wrap at DEPTH, which need not be a power of two
	function automatic ptr_t next_ptr(input ptr_t ptr);
		ptr_t nxt;
		if (ptr == ptr_t'(DEPTH - 1))
			nxt = '0;
		else
			nxt = ptr + ptr_t'(1);
		return nxt;
	endfunction

	assign full       = count == count_t'(DEPTH);
	assign head_valid = count != '0;
	// The oldest entry is presented without a register stage
	assign head_bundle = entries[rd_ptr];

	// When full, a pop in the same cycle frees the slot the push needs
	assign in_ready = !full || head_ready;
	assign push     = in_valid && in_ready;
	assign pop      = head_valid && head_ready;

	// ================================================
	// Pointers and occupancy
	// ================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the count unchanged
			if (push && !pop)
				count <= count + count_t'(1);
			else if (pop && !push)
				count <= count - count_t'(1);
		end
	end

	// Storage; a written entry is visible at the head right after the edge
	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= in_bundle;
	end

endmodule

`default_nettype wire

/* logic/postfix_scan.sv */
// ==================================================
// Postfix scanner
// Classifies the second parcel of a bundle and
// extracts the extended register numbers
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module postfix_scan (
	input  wire isa_pkg::bundle_t bundle,
	output decode_pkg::postfix_t  postfix
);
	import isa_pkg::*;

	// ================================================
	// Second parcel layout, in bundle bit positions
	// ================================================

	// Postfix opcode occupies the low seven bits of the second parcel
	localparam int PF_OP_LSB  = 48;
	// Extended register numbers, seven bits each, packed above the opcode
	localparam int PF_RS1_LSB = 55;
	localparam int PF_RS2_LSB = 62;
	localparam int PF_RD_LSB  = 69;

	logic [6:0] pf_opcode;

	assign pf_opcode = bundle[PF_OP_LSB +: 7];

	always_comb
	begin
		// Any parcel that is not a postfix opcode is just the next instruction
		postfix.has_rext = pf_opcode == OP_REXT;
		postfix.has_imma = pf_opcode == OP_IMMA;

		// The slices are taken unconditionally
		// Decoders only look at them when has_rext is set
		postfix.rs1 = aregno_t'(bundle[PF_RS1_LSB +: 7]);
		postfix.rs2 = aregno_t'(bundle[PF_RS2_LSB +: 7]);
		postfix.rd  = aregno_t'(bundle[PF_RD_LSB +: 7]);
	end

endmodule

`default_nettype wire

/* logic/decode_rs1.sv */
// ==================================================
// Rs1 decoder
// Picks the first source register by opcode class
// and flags the zero and IP registers
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module decode_rs1 (
	input  wire isa_pkg::base_instr_t instr,
	input  wire decode_pkg::postfix_t postfix,
	output isa_pkg::aregno_t          rs1,
	output logic                      rs1_zero,
	output logic                      rs1_ip
);
	import isa_pkg::*;
	import decode_pkg::*;

	// Returns register 0 for instructions that have no first source
	function automatic aregno_t sel_rs1(input base_instr_t ins, input postfix_t pf);
		aregno_t field;
		aregno_t result;
		// A register-extension postfix replaces the six-bit base field
		field = pf.has_rext ? pf.rs1 : {1'b0, ins.rs1};
		if (pf.has_imma)
			// The immediate postfix supplies operand A, so no register is read
			result = '0;
		else
		begin
			case (ins.opcode)
				// ALU immediate forms
				OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_SHIFT:
					result = field;
				OP_ADD:
					result = field;
				// Memory ops use Rs1 as the base address
				OP_LOAD, OP_STORE:
					result = field;
				OP_BCC, OP_CSR:
					result = field;
				// Stack ops use an implied pointer, NOP reads nothing
				default:
					result = '0;
			endcase
		end
		return result;
	endfunction

	always_comb
	begin
		rs1 = sel_rs1(instr, postfix);
		// Flags follow the final number, so an extended 127 or 62 is caught too
		rs1_zero = rs1 == AREG_ZERO;
		rs1_ip   = rs1 == AREG_IP;
	end

endmodule

`default_nettype wire

/* logic/decode_rs2_rd.sv */
// ==================================================
// Rs2 and Rd decoder
// Selects the second source and the destination,
// flags both and detects illegal opcodes
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module decode_rs2_rd (
	input  wire isa_pkg::base_instr_t instr,
	input  wire decode_pkg::postfix_t postfix,
	output isa_pkg::aregno_t          rs2,
	output isa_pkg::aregno_t          rd,
	output decode_pkg::areg_flags_t   rs2_flags,
	output decode_pkg::areg_flags_t   rd_flags,
	output logic                      illegal
);
	import isa_pkg::*;
	import decode_pkg::*;

	// Second source is only read by register-register ALU ops, stores and branches
	function automatic aregno_t sel_rs2(input base_instr_t ins, input postfix_t pf);
		aregno_t result;
		case (ins.opcode)
			OP_ADD, OP_STORE, OP_BCC:
				result = pf.has_rext ? pf.rs2 : {1'b0, ins.rs2};
			default:
				result = '0;
		endcase
		return result;
	endfunction

	// Destination for everything that writes a register, POP included
	function automatic aregno_t sel_rd(input base_instr_t ins, input postfix_t pf);
		aregno_t result;
		case (ins.opcode)
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_SHIFT,
			OP_ADD, OP_LOAD, OP_CSR, OP_POP:
				result = pf.has_rext ? pf.rd : {1'b0, ins.rd};
			default:
				result = '0;
		endcase
		return result;
	endfunction

	function automatic areg_flags_t flags_of(input aregno_t regno);
		areg_flags_t f;
		f.zero = regno == AREG_ZERO;
		f.ip   = regno == AREG_IP;
		return f;
	endfunction

	function automatic logic is_illegal(input opcode_t op);
		logic bad;
		case (op)
			OP_NOP, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_SHIFT,
			OP_ADD, OP_LOAD, OP_STORE, OP_BCC, OP_CSR, OP_PUSH, OP_POP:
				bad = 1'b0;
			// A postfix opcode cannot start an instruction
			OP_REXT, OP_IMMA:
				bad = 1'b1;
			// Unassigned encodings
			default:
				bad = 1'b1;
		endcase
		return bad;
	endfunction

	always_comb
	begin
		rs2       = sel_rs2(instr, postfix);
		rd        = sel_rd(instr, postfix);
		rs2_flags = flags_of(rs2);
		rd_flags  = flags_of(rd);
		illegal   = is_illegal(instr.opcode);
	end

endmodule

`default_nettype wire

/* logic/decode_out_reg.sv */
// ==================================================
// Decode output register
// Packs one decoded record and holds it until the
// rename side accepts it
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module decode_out_reg (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       head_valid,
	output logic                      head_ready,
	input  wire isa_pkg::base_instr_t instr,
	input  wire decode_pkg::postfix_t postfix,
	input  wire isa_pkg::aregno_t     rs1,
	input  wire                       rs1_zero,
	input  wire                       rs1_ip,
	input  wire isa_pkg::aregno_t     rs2,
	input  wire isa_pkg::aregno_t     rd,
	input  wire decode_pkg::areg_flags_t rs2_flags,
	input  wire decode_pkg::areg_flags_t rd_flags,
	input  wire                       illegal,
	output logic                      out_valid,
	input  wire                       out_ready,
	output decode_pkg::decoded_t      out_rec
);
	import decode_pkg::*;

	decoded_t next_rec;
	logic     load;

	// Room exists when the register is empty or its record leaves this cycle
	assign head_ready = !out_valid || out_ready;
	assign load       = head_valid && head_ready;

	always_comb
	begin
		next_rec.instr         = instr;
		next_rec.rs1           = rs1;
		next_rec.rs2           = rs2;
		next_rec.rd            = rd;
		next_rec.flags.rs1.zero = rs1_zero;
		next_rec.flags.rs1.ip   = rs1_ip;
		next_rec.flags.rs2     = rs2_flags;
		next_rec.flags.rd      = rd_flags;
		next_rec.illegal       = illegal;
		next_rec.has_rext      = postfix.has_rext;
		next_rec.has_imma      = postfix.has_imma;
	end

	// Valid refills from the head whenever the slot is free
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (head_ready)
			out_valid <= head_valid;
	end

	// Record only changes on a load, so it holds under back-pressure
	always_ff @(posedge clk)
	begin
		if (load)
			out_rec <= next_rec;
	end

endmodule

`default_nettype wire

/* logic/regfield_decode_top.sv */
// ==================================================
// Register-field decode stage
// Queue, postfix scan, register decoders and the
// output register toward rename
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module regfield_decode_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire isa_pkg::bundle_t in_bundle,
	output logic                  out_valid,
	input  wire                   out_ready,
	output decode_pkg::decoded_t  out_rec
);
	import isa_pkg::*;
	import decode_pkg::*;

	// Head of the queue, decoded combinationally in the same cycle
	bundle_t     head_bundle;
	logic        head_valid;
	logic        head_ready;
	postfix_t    postfix;
	aregno_t     rs1;
	aregno_t     rs2;
	aregno_t     rd;
	logic        rs1_zero;
	logic        rs1_ip;
	areg_flags_t rs2_flags;
	areg_flags_t rd_flags;
	logic        illegal;

	fetch_queue #(
		.DEPTH (QUEUE_DEPTH)
	) fetch_queue_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_bundle   (in_bundle),
		.head_valid  (head_valid),
		.head_ready  (head_ready),
		.head_bundle (head_bundle)
	);

	postfix_scan postfix_scan_inst (
		.bundle  (head_bundle),
		.postfix (postfix)
	);

	decode_rs1 decode_rs1_inst (
		.instr    (head_bundle.base),
		.postfix  (postfix),
		.rs1      (rs1),
		.rs1_zero (rs1_zero),
		.rs1_ip   (rs1_ip)
	);

	decode_rs2_rd decode_rs2_rd_inst (
		.instr     (head_bundle.base),
		.postfix   (postfix),
		.rs2       (rs2),
		.rd        (rd),
		.rs2_flags (rs2_flags),
		.rd_flags  (rd_flags),
		.illegal   (illegal)
	);

	// Single pipeline stage, one record per cycle when not stalled
	decode_out_reg decode_out_reg_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_valid (head_valid),
		.head_ready (head_ready),
		.instr      (head_bundle.base),
		.postfix    (postfix),
		.rs1        (rs1),
		.rs1_zero   (rs1_zero),
		.rs1_ip     (rs1_ip),
		.rs2        (rs2),
		.rd         (rd),
		.rs2_flags  (rs2_flags),
		.rd_flags   (rd_flags),
		.illegal    (illegal),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_rec    (out_rec)
	);

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// ==================================================
// Testbench clock and reset
// 100 ns clock, reset held low for four cycles
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Reset releases on a rising edge after four full cycles
	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/regfield_decode_tb.sv */
// ==================================================
// Register-field decode testbench
// Replays the vector file through the stage, once
// with a free output and once under back-pressure
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module regfield_decode_tb;
	import isa_pkg::*;
	import decode_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int PASSES      = 2;

	// Stimulus and expected register fields of one test line
	typedef struct packed {
		bundle_t    bundle;
		aregno_t    rs1;
		aregno_t    rs2;
		aregno_t    rd;
		reg_flags_t flags;
		logic       illegal;
	} test_vec_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	bundle_t     in_bundle;
	logic        out_valid;
	logic        out_ready;
	decoded_t    out_rec;

	string       names[$];
	test_vec_t   vecs[$];
	// Indices of accepted bundles, oldest first
	int          exp_q[$];
	int          accepted;
	int          delivered;
	int          total;
	int          cycle;
	int          timeout_limit = 100;
	int          checks;
	int          value_errors;
	int          other_errors;
	logic        random_ready;
	logic        saw_full;
	int unsigned seed;

	tb_clock_gen clock_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	regfield_decode_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) regfield_decode_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_bundle (in_bundle),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rec   (out_rec)
	);

	// ================================================
	// Compare tasks
	// ================================================
	task automatic check_areg(input string name, input aregno_t exp, input aregno_t act);
		checks++;
		if (act !== exp)
		begin
			value_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flags(input string name, input reg_flags_t exp, input reg_flags_t act);
		checks++;
		if (act !== exp)
		begin
			value_errors++;
			$display("FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			value_errors++;
			$display("FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_instr(input string name, input base_instr_t exp, input base_instr_t act);
		checks++;
		if (act !== exp)
		begin
			value_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Postfix kind comes from the opcode in the low bits of the second parcel
	function automatic logic parcel_holds(input bundle_t b, input opcode_t op);
		return b.parcel[6:0] == op;
	endfunction

	task automatic check_record(input int idx);
		string     nm;
		test_vec_t v;
		nm = names[idx];
		v  = vecs[idx];
		// The base instruction identifies the bundle, so order slips show up here
		check_instr({nm, " instr"}, v.bundle.base, out_rec.instr);
		check_areg({nm, " rs1"}, v.rs1, out_rec.rs1);
		check_areg({nm, " rs2"}, v.rs2, out_rec.rs2);
		check_areg({nm, " rd"}, v.rd, out_rec.rd);
		check_flags({nm, " flags"}, v.flags, out_rec.flags);
		check_bit({nm, " illegal"}, v.illegal, out_rec.illegal);
		check_bit({nm, " has_rext"}, parcel_holds(v.bundle, OP_REXT), out_rec.has_rext);
		check_bit({nm, " has_imma"}, parcel_holds(v.bundle, OP_IMMA), out_rec.has_imma);
	endtask

	// The queue plus the output register hold DEPTH plus one bundles
	task automatic check_in_ready();
		int in_flight;
		in_flight = accepted - delivered;
		if (in_flight > QUEUE_DEPTH + 1)
		begin
			other_errors++;
			$display("%0d bundles in flight, more than the stage can hold", in_flight);
		end
		if (!in_ready && in_flight != QUEUE_DEPTH + 1)
		begin
			other_errors++;
			$display("in_ready dropped with only %0d bundles in flight", in_flight);
		end
		if (in_flight == QUEUE_DEPTH + 1 && !out_ready && in_ready)
		begin
			other_errors++;
			$display("in_ready stayed high with the queue full and the output stalled");
		end
		if (!in_ready)
			saw_full = 1'b1;
	endtask

	task automatic report_counts();
		$display("Checks run: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
	endtask

	// ================================================
	// Vector file
	// ================================================
	task automatic load_tests();
		int               fd;
		int               n;
		string            word;
		logic [8*256-1:0] rest;
		logic [95:0]      b;
		logic [6:0]       r1;
		logic [6:0]       r2;
		logic [6:0]       rdn;
		logic [5:0]       fl;
		logic             il;
		test_vec_t        v;
		fd = $fopen("sim/regfield_decode_tests.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			n = $fscanf(fd, "%s", word);
			if (n != 1)
				break;
			// Comment lines start with a hash and are skipped whole
			if (word[0] == "#")
			begin
				n = $fgets(rest, fd);
				continue;
			end
			n = $fscanf(fd, "%h %h %h %h %h %h", b, r1, r2, rdn, fl, il);
			if (n != 6)
			begin
				other_errors++;
				$display("Line for test %s in the tests file is malformed", word);
				break;
			end
			v.bundle  = b;
			v.rs1     = r1;
			v.rs2     = r2;
			v.rd      = rdn;
			v.flags   = fl;
			v.illegal = il;
			names.push_back(word);
			vecs.push_back(v);
		end
		$fclose(fd);
	endtask

	// ================================================
	// Stimulus
	// ================================================

	// Sends every vector once per pass and waits for each handshake
	task automatic run_passes();
		int        p;
		int        i;
		test_vec_t v;
		for (p = 0; p < PASSES; p++)
		begin
			// Second pass stalls the output at random
			random_ready <= (p == 1);
			for (i = 0; i < vecs.size(); i++)
			begin
				v = vecs[i];
				in_valid  <= 1'b1;
				in_bundle <= v.bundle;
				@(posedge clk);
				while (!in_ready)
					@(posedge clk);
				exp_q.push_back(i);
				accepted++;
			end
		end
		in_valid <= 1'b0;
		while (delivered < total)
			@(posedge clk);
	endtask

	// Roughly three cycles in ten accept a record, so the queue backs up
	initial
	begin
		seed      = $urandom(32'he679);
		out_ready = 1'b0;
		forever
		begin
			@(posedge clk);
			if (!rst_n)
				out_ready <= 1'b0;
			else if (random_ready)
				out_ready <= ($urandom % 10) < 3;
			else
				out_ready <= 1'b1;
		end
	end

	// ================================================
	// Monitor and cycle limit
	// ================================================

	// Sampled on the falling edge, where the handshake signals are settled
	always @(negedge clk)
	begin
		cycle = cycle + 1;
		if (cycle >= timeout_limit)
		begin
			other_errors++;
			$display("Timeout after %0d cycles with %0d of %0d records received",
				cycle, delivered, total);
			report_counts();
			$display("TEST FAIL");
			$finish;
		end
		else if (rst_n)
		begin
			check_in_ready();
			// A record seen here transfers on the next rising edge
			if (out_valid && out_ready)
			begin
				if (exp_q.size() == 0)
				begin
					other_errors++;
					$display("A record came out with no bundle outstanding");
				end
				else
					check_record(exp_q.pop_front());
				delivered++;
			end
		end
	end

	initial
	begin
		in_valid     = 1'b0;
		in_bundle    = '0;
		random_ready = 1'b0;
		saw_full     = 1'b0;
		load_tests();
		total         = PASSES * vecs.size();
		timeout_limit = 20 * total + 100;
		if (vecs.size() == 0)
		begin
			other_errors++;
			$display("No tests could be read from sim/regfield_decode_tests.txt");
			report_counts();
			$display("TEST FAIL");
			$finish;
		end
		else
		begin
			@(posedge rst_n);
			@(negedge clk);
			check_bit("reset out_valid", 1'b0, out_valid);
			check_bit("reset in_ready", 1'b1, in_ready);
			@(posedge clk);
			run_passes();
			// A duplicated record would reach the monitor within these cycles
			repeat (4) @(posedge clk);
			if (!saw_full)
			begin
				other_errors++;
				$display("The queue never filled while the output was stalled");
			end
			report_counts();
			if (value_errors + other_errors == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* list.f */
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/fetch_queue.sv
logic/postfix_scan.sv
logic/decode_rs1.sv
logic/decode_rs2_rd.sv
logic/decode_out_reg.sv
logic/regfield_decode_top.sv
sim/tb_clock_gen.sv
sim/regfield_decode_tb.sv

/* sim/regfield_decode_tests.txt */
# name  bundle (second parcel then base, 24 hex digits)  rs1 rs2 rd (hex)
# flags (hex, rs1 zero/ip, rs2 zero/ip, rd zero/ip from bit 5 down)  illegal
addi_base        000000000000000000486284 03 00 05 00 0
andi_base        0000000000000000000A8508 14 00 0a 00 0
ori_base         000000000000000000004089 02 00 01 00 0
xori_all63       000000000000000001FFFF8A 3f 00 3f 00 0
cmpi_rs1_ip      00000000000000000007C00B 3e 00 00 10 0
shift_rd_ip      00000000000000000020FF0C 07 00 3e 01 0
add_base         000000000000000000698590 0c 0d 0b 00 0
load_base        0000000000000000011C50A0 22 00 21 00 0
store_base       0000000000000000009A48A8 12 13 00 00 0
bcc_rs2_ip       000000000000000001F0C2B0 06 3e 00 04 0
csr_upper        00000000000002468B553407 29 00 28 00 0
nop_fields       00000000000000000038C280 00 00 00 00 0
push_fields      0000000000000000001840B8 00 00 00 00 0
pop_rd           0000000000000000001844B9 00 00 09 00 0
undefined_op     00000000000000000030A255 00 00 00 00 1
rext_in_base     0000000000000000000820FA 00 00 00 00 1
add_rext         00000CD9727A000000184090 64 65 66 00 0
load_rext_zero   00000FECBFFA0000000820A0 7f 00 7f 22 0
store_rext       000008DFDF7A000000000028 3e 7f 00 18 0
bcc_rext         000000AFA87A000000000030 50 3e 00 04 0
push_rext        00000182C57A000000000038 00 00 00 00 0
pop_rext_ip      000007C080FA000000000039 00 00 3e 01 0
addi_imma        ABCD0000007B000000490384 00 00 07 00 0
add_imma         00000000007B000001F7C190 00 3e 03 04 0
store_imma       00000000007B00000030A028 00 06 00 00 0
csr_imma         00000000007B000000009F07 00 00 3e 01 0
plain_parcel     000000184090000000006120 03 00 02 00 0
